// ==== Makefile ====
# Verilator build and run of the bus master testbench

SIM  := obj_dir/Vtb_bam_master
SRCS := $(filter-out +%,$(shell cat list.f)) common/bam_defs.svh

.PHONY: all run clean

all: run

$(SIM): list.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ns \
		-f list.f --top-module tb_bam_master -o Vtb_bam_master

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

// ==== cmd_issue/bam_cmd_sequencer.sv ====
/*
 * Command sequencer: FSM that pops commands, latches them and
 * runs the write beat counter, plus the registered ready flags.
 */

`timescale 1ns/1ns

`include "bam_defs.svh"

module bam_cmd_sequencer (
  input  logic                    clk,
  input  logic                    srst_reg,
  input  logic                    cmd_empty_i,
  input  bam_cmd_pkg::bam_cmd_t   cmd_rdata_i,
  input  logic                    bus_waitreq_i,
  input  logic                    credit_ok_i,
  output logic                    cmd_pop_o,
  output logic                    wdata_pop_o,
  output logic                    wr_beat_o,
  output logic                    rd_req_o,
  output bam_bus_pkg::bam_addr_t  req_addr_o,
  output bam_bus_pkg::bam_be_t    req_be_o,
  output bam_bus_pkg::bam_burst_t req_burst_o
);

  bam_cmd_pkg::bam_state_e state;
  bam_cmd_pkg::bam_state_e state_nxt;
  bam_cmd_pkg::bam_cmd_t   cmd_q;
  bam_bus_pkg::bam_burst_t beat_cnt;
  logic                    cmd_avail_q;
  logic                    waitreq_q;
  logic                    last_beat;

  // --------------------------------------------------
  // ready flags, sampled one cycle ahead of the FSM
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (srst_reg) begin
      cmd_avail_q <= 1'b0;
      waitreq_q   <= 1'b0;
    end else begin
      cmd_avail_q <= ~cmd_empty_i;
      waitreq_q   <= bus_waitreq_i;
    end
  end

  // --------------------------------------------------
  // state machine
  // --------------------------------------------------
  assign last_beat = (beat_cnt == `BAM_BURST_W'(1));

  always_ff @(posedge clk) begin
    if (srst_reg) begin
      state <= bam_cmd_pkg::ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      bam_cmd_pkg::ST_IDLE: begin
        // waitrequest and credits are only looked at here
        if (cmd_avail_q && !waitreq_q && credit_ok_i) begin
          state_nxt = bam_cmd_pkg::ST_POP;
        end
      end
      bam_cmd_pkg::ST_POP: begin
        // head word is still visible while it is being popped
        if (cmd_rdata_i.op == bam_cmd_pkg::OP_WRITE) begin
          state_nxt = bam_cmd_pkg::ST_WRITE;
        end else begin
          state_nxt = bam_cmd_pkg::ST_READ;
        end
      end
      bam_cmd_pkg::ST_WRITE: begin
        if (last_beat) begin
          state_nxt = bam_cmd_pkg::ST_IDLE;
        end
      end
      bam_cmd_pkg::ST_READ: begin
        state_nxt = bam_cmd_pkg::ST_IDLE;
      end
      default: begin
        state_nxt = bam_cmd_pkg::ST_IDLE;
      end
    endcase
  end

  // --------------------------------------------------
  // command latch and write beat counter
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (state == bam_cmd_pkg::ST_POP) begin
      cmd_q <= cmd_rdata_i;
    end
  end

  always_ff @(posedge clk) begin
    if (srst_reg) begin
      beat_cnt <= '0;
    end else if (state == bam_cmd_pkg::ST_POP) begin
      beat_cnt <= cmd_rdata_i.burst;
    end else if (state == bam_cmd_pkg::ST_WRITE) begin
      beat_cnt <= beat_cnt - `BAM_BURST_W'(1);
    end
  end

  assign cmd_pop_o   = (state == bam_cmd_pkg::ST_POP);
  // one data word per beat, window writes included
  assign wdata_pop_o = (state == bam_cmd_pkg::ST_WRITE);
  assign wr_beat_o   = (state == bam_cmd_pkg::ST_WRITE);
  assign rd_req_o    = (state == bam_cmd_pkg::ST_READ);

  assign req_addr_o  = cmd_q.addr;
  assign req_be_o    = cmd_q.be;
  assign req_burst_o = cmd_q.burst;

endmodule

// ==== cmd_issue/bam_req_driver.sv ====
/*
 * Bus request driver: output register stage with address
 * alignment, byte enable select and protected window suppression.
 */

`timescale 1ns/1ns

`include "bam_defs.svh"

module bam_req_driver (
  input  logic                    clk,
  input  logic                    srst_reg,
  input  logic                    wr_beat_i,
  input  logic                    rd_req_i,
  input  bam_bus_pkg::bam_addr_t  req_addr_i,
  input  bam_bus_pkg::bam_be_t    req_be_i,
  input  bam_bus_pkg::bam_burst_t req_burst_i,
  input  bam_bus_pkg::bam_data_t  wdata_i,
  input  bam_bus_pkg::bam_be_t    wbe_i,
  output logic                    bus_write_o,
  output logic                    bus_read_o,
  output bam_bus_pkg::bam_addr_t  bus_addr_o,
  output bam_bus_pkg::bam_data_t  bus_wdata_o,
  output bam_bus_pkg::bam_be_t    bus_be_o,
  output bam_bus_pkg::bam_burst_t bus_burst_o
);

  bam_bus_pkg::bam_addr_t addr_aligned;
  logic                   win_hit;
  logic                   wr_allowed;

  // --------------------------------------------------
  // address decode
  // --------------------------------------------------
  assign addr_aligned = {req_addr_i[`BAM_ADDR_W-1:`BAM_ALIGN_BITS],
                         {`BAM_ALIGN_BITS{1'b0}}};

  // protected window is checked on the aligned address
  assign win_hit    = |addr_aligned[`BAM_WIN_HI:`BAM_WIN_LO];
  assign wr_allowed = wr_beat_i & ~win_hit;

  // --------------------------------------------------
  // request strobes
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (srst_reg) begin
      bus_write_o <= 1'b0;
      bus_read_o  <= 1'b0;
    end else begin
      bus_write_o <= wr_allowed;
      bus_read_o  <= rd_req_i;
    end
  end

  // --------------------------------------------------
  // request payload
  // --------------------------------------------------
  // held between requests, address and burst stay fixed over a burst
  always_ff @(posedge clk) begin
    if (wr_beat_i || rd_req_i) begin
      bus_addr_o  <= addr_aligned;
      bus_burst_o <= req_burst_i;
      bus_wdata_o <= wr_allowed ? wdata_i : '0;
      if (rd_req_i) begin
        bus_be_o <= req_be_i;
      end else begin
        // suppressed beats show no byte lanes at all
        bus_be_o <= wr_allowed ? wbe_i : '0;
      end
    end
  end

endmodule

// ==== common/bam_bus_pkg.sv ====
/*
 * Bus side types: address, data, byte enable, burst count,
 * response and the completion entry.
 */

package bam_bus_pkg;

  `include "bam_defs.svh"

  typedef logic [`BAM_ADDR_W-1:0]  bam_addr_t;
  typedef logic [`BAM_DATA_W-1:0]  bam_data_t;
  typedef logic [`BAM_BE_W-1:0]    bam_be_t;
  typedef logic [`BAM_BURST_W-1:0] bam_burst_t;

  // slave response, any nonzero value counts as an error
  typedef logic [1:0] bam_resp_t;

  // one completion buffer entry
  typedef struct packed {
    logic      err;
    bam_data_t data;
  } bam_cpl_t;

endpackage

// ==== common/bam_cmd_pkg.sv ====
/*
 * Command side types: opcode, sequencer states and the
 * packed command word read from the command FIFO.
 */

package bam_cmd_pkg;

  // --------------------------------------------------
  // opcodes
  // --------------------------------------------------
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } bam_op_e;

  // --------------------------------------------------
  // sequencer states
  // --------------------------------------------------
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_POP   = 2'd1,
    ST_WRITE = 2'd2,
    ST_READ  = 2'd3
  } bam_state_e;

  // --------------------------------------------------
  // command word, msb first
  // --------------------------------------------------
  // be is only used by reads, writes take it from the data FIFO
  typedef struct packed {
    bam_op_e                op;
    bam_bus_pkg::bam_burst_t burst;
    bam_bus_pkg::bam_be_t    be;
    bam_bus_pkg::bam_addr_t  addr;
  } bam_cmd_t;

endpackage

// ==== common/bam_defs.svh ====
/*
 * Bus master widths, depths and the protected address window.
 * One data width only, with the byte enables derived from it.
 */

`ifndef BAM_DEFS_SVH
`define BAM_DEFS_SVH

// --------------------------------------------------
// bus fields
// --------------------------------------------------
`define BAM_DATA_W      64
`define BAM_BE_W        8
`define BAM_ADDR_W      32

// low address bits forced to zero on the bus (8-byte beats)
`define BAM_ALIGN_BITS  3

// --------------------------------------------------
// bursts and completion storage
// --------------------------------------------------
`define BAM_BURST_W     4
`define BAM_MAX_BURST   15

`define BAM_CPL_DEPTH   64
`define BAM_CPL_AW      6
// must hold the value BAM_CPL_DEPTH itself
`define BAM_CREDIT_W    7

// --------------------------------------------------
// protected window
// --------------------------------------------------
// an address is out of range when any bit in [HI:LO] is set
`define BAM_WIN_LO      15
`define BAM_WIN_HI      21

`endif

// ==== cpl_buffer/bam_cpl_buffer.sv ====
/*
 * Completion buffer: read data capture, inferred storage with
 * read and write pointers, and the credit counter.
 */

`timescale 1ns/1ns

`include "bam_defs.svh"

module bam_cpl_buffer (
  input  logic                    clk,
  input  logic                    srst_reg,
  input  logic                    bus_rvalid_i,
  input  bam_bus_pkg::bam_data_t  bus_rdata_i,
  input  bam_bus_pkg::bam_resp_t  bus_resp_i,
  input  logic                    rd_issue_i,
  input  bam_bus_pkg::bam_burst_t rd_burst_i,
  input  logic                    cpl_pop_i,
  output logic                    cpl_empty_o,
  output bam_bus_pkg::bam_cpl_t   cpl_data_o,
  output logic                    credit_ok_o
);

  logic                       rvalid_q;
  bam_bus_pkg::bam_data_t     rdata_q;
  logic                       err_q;
  bam_bus_pkg::bam_cpl_t      mem [`BAM_CPL_DEPTH];
  logic [`BAM_CPL_AW:0]       wr_ptr;
  logic [`BAM_CPL_AW:0]       rd_ptr;
  logic [`BAM_CPL_AW:0]       wr_ptr_nxt;
  logic [`BAM_CPL_AW:0]       rd_ptr_nxt;
  logic [`BAM_CREDIT_W-1:0]   credit;
  logic [`BAM_CREDIT_W-1:0]   credit_take;
  logic [`BAM_CREDIT_W-1:0]   credit_nxt;

  // --------------------------------------------------
  // read data capture
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (srst_reg) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus_rvalid_i;
    end
  end

  always_ff @(posedge clk) begin
    rdata_q <= bus_rdata_i;
    err_q   <= |bus_resp_i;
  end

  // --------------------------------------------------
  // storage and pointers
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rvalid_q) begin
      mem[wr_ptr[`BAM_CPL_AW-1:0]] <= '{err: err_q, data: rdata_q};
    end
  end

  // extra msb tells a wrapped pointer from an equal one
  assign wr_ptr_nxt = wr_ptr + (`BAM_CPL_AW+1)'(rvalid_q);
  assign rd_ptr_nxt = rd_ptr + (`BAM_CPL_AW+1)'(cpl_pop_i);

  always_ff @(posedge clk) begin
    if (srst_reg) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      cpl_empty_o <= 1'b1;
    end else begin
      wr_ptr      <= wr_ptr_nxt;
      rd_ptr      <= rd_ptr_nxt;
      cpl_empty_o <= (wr_ptr_nxt == rd_ptr_nxt);
    end
  end

  // show-ahead head entry
  assign cpl_data_o = mem[rd_ptr[`BAM_CPL_AW-1:0]];

  // --------------------------------------------------
  // credits
  // --------------------------------------------------
  // one credit per buffer entry, a read takes its whole burst up front
  assign credit_take = rd_issue_i ? `BAM_CREDIT_W'(rd_burst_i) : '0;
  assign credit_nxt  = credit + `BAM_CREDIT_W'(cpl_pop_i) - credit_take;

  // flag follows the updated count so the next start sees this debit
  always_ff @(posedge clk) begin
    if (srst_reg) begin
      credit      <= `BAM_CREDIT_W'(`BAM_CPL_DEPTH);
      credit_ok_o <= 1'b1;
    end else begin
      credit      <= credit_nxt;
      credit_ok_o <= (credit_nxt >= `BAM_CREDIT_W'(`BAM_MAX_BURST));
    end
  end

endmodule

// ==== list.f ====
+incdir+common
common/bam_bus_pkg.sv
common/bam_cmd_pkg.sv
cmd_issue/bam_cmd_sequencer.sv
cmd_issue/bam_req_driver.sv
cpl_buffer/bam_cpl_buffer.sv
source/bam_master_top.sv
test/tb_bam_master.sv

// ==== source/bam_master_top.sv ====
/*
 * Bus master top level: command sequencer, bus request driver
 * and completion buffer.
 */

`timescale 1ns/1ns

module bam_master_top (
  input  logic                    clk,
  input  logic                    srst_reg,

  // command FIFO, show-ahead
  input  logic                    cmd_empty_i,
  input  bam_cmd_pkg::bam_cmd_t   cmd_rdata_i,
  output logic                    cmd_pop_o,

  // write data FIFO, show-ahead
  input  bam_bus_pkg::bam_data_t  wdata_i,
  input  bam_bus_pkg::bam_be_t    wbe_i,
  output logic                    wdata_pop_o,

  // slave bus
  output logic                    bus_write_o,
  output logic                    bus_read_o,
  output bam_bus_pkg::bam_addr_t  bus_addr_o,
  output bam_bus_pkg::bam_data_t  bus_wdata_o,
  output bam_bus_pkg::bam_be_t    bus_be_o,
  output bam_bus_pkg::bam_burst_t bus_burst_o,
  input  logic                    bus_waitreq_i,
  input  bam_bus_pkg::bam_data_t  bus_rdata_i,
  input  logic                    bus_rvalid_i,
  input  bam_bus_pkg::bam_resp_t  bus_resp_i,

  // completion consumer
  output logic                    cpl_empty_o,
  output bam_bus_pkg::bam_cpl_t   cpl_data_o,
  input  logic                    cpl_pop_i
);

  logic                    wr_beat;
  logic                    rd_req;
  bam_bus_pkg::bam_addr_t  req_addr;
  bam_bus_pkg::bam_be_t    req_be;
  bam_bus_pkg::bam_burst_t req_burst;
  logic                    credit_ok;

  bam_cmd_sequencer u_seq (
    .clk           ( clk           ),
    .srst_reg      ( srst_reg      ),
    .cmd_empty_i   ( cmd_empty_i   ),
    .cmd_rdata_i   ( cmd_rdata_i   ),
    .bus_waitreq_i ( bus_waitreq_i ),
    .credit_ok_i   ( credit_ok     ),
    .cmd_pop_o     ( cmd_pop_o     ),
    .wdata_pop_o   ( wdata_pop_o   ),
    .wr_beat_o     ( wr_beat       ),
    .rd_req_o      ( rd_req        ),
    .req_addr_o    ( req_addr      ),
    .req_be_o      ( req_be        ),
    .req_burst_o   ( req_burst     )
  );

  bam_req_driver u_drv (
    .clk         ( clk         ),
    .srst_reg    ( srst_reg    ),
    .wr_beat_i   ( wr_beat     ),
    .rd_req_i    ( rd_req      ),
    .req_addr_i  ( req_addr    ),
    .req_be_i    ( req_be      ),
    .req_burst_i ( req_burst   ),
    .wdata_i     ( wdata_i     ),
    .wbe_i       ( wbe_i       ),
    .bus_write_o ( bus_write_o ),
    .bus_read_o  ( bus_read_o  ),
    .bus_addr_o  ( bus_addr_o  ),
    .bus_wdata_o ( bus_wdata_o ),
    .bus_be_o    ( bus_be_o    ),
    .bus_burst_o ( bus_burst_o )
  );

  // the read strobe is also the credit debit strobe
  bam_cpl_buffer u_cpl (
    .clk          ( clk          ),
    .srst_reg     ( srst_reg     ),
    .bus_rvalid_i ( bus_rvalid_i ),
    .bus_rdata_i  ( bus_rdata_i  ),
    .bus_resp_i   ( bus_resp_i   ),
    .rd_issue_i   ( rd_req       ),
    .rd_burst_i   ( req_burst    ),
    .cpl_pop_i    ( cpl_pop_i    ),
    .cpl_empty_o  ( cpl_empty_o  ),
    .cpl_data_o   ( cpl_data_o   ),
    .credit_ok_o  ( credit_ok    )
  );

endmodule

// ==== test/tb_bam_master.sv ====
/*
 * Testbench for the bus master with command and write data FIFO models,
 * a slave model with random read latency, the stimulus table and checks.
 */

`timescale 1ns/1ns

`include "bam_defs.svh"

module tb_bam_master;

  localparam int NUM_ENTRIES = 19;
  localparam int DRAIN_LIMIT = 2000;

  typedef struct packed {
    logic [1:0]              grp;
    bam_cmd_pkg::bam_op_e    op;
    bam_bus_pkg::bam_addr_t  addr;
    bam_bus_pkg::bam_burst_t burst;
    bam_bus_pkg::bam_be_t    be;
  } tbl_entry_t;

  typedef struct packed {
    logic [7:0]              idx;
    logic                    first;
    bam_bus_pkg::bam_addr_t  addr;
    bam_bus_pkg::bam_data_t  data;
    bam_bus_pkg::bam_be_t    be;
    bam_bus_pkg::bam_burst_t burst;
  } exp_wr_t;

  typedef struct packed {
    logic [7:0]              idx;
    bam_bus_pkg::bam_addr_t  addr;
    bam_bus_pkg::bam_be_t    be;
    bam_bus_pkg::bam_burst_t burst;
  } exp_rd_t;

  typedef struct packed {
    logic [7:0]            idx;
    bam_bus_pkg::bam_cpl_t cpl;
  } exp_cpl_t;

  typedef struct packed {
    bam_bus_pkg::bam_resp_t resp;
    bam_bus_pkg::bam_data_t data;
  } beat_t;

  // group 0 is basic traffic, 1 the credit stall and 2 the waitrequest hold
  tbl_entry_t tbl [NUM_ENTRIES] = '{
    '{2'd0, bam_cmd_pkg::OP_WRITE, 32'h0000_1003, 4'd4,  8'h00},
    '{2'd0, bam_cmd_pkg::OP_READ,  32'h0000_1000, 4'd4,  8'hff},
    '{2'd0, bam_cmd_pkg::OP_WRITE, 32'h0000_8000, 4'd3,  8'h00},
    '{2'd0, bam_cmd_pkg::OP_WRITE, 32'h0000_1020, 4'd2,  8'h00},
    '{2'd0, bam_cmd_pkg::OP_READ,  32'h0000_1020, 4'd2,  8'h0f},
    '{2'd0, bam_cmd_pkg::OP_READ,  32'h0000_8000, 4'd2,  8'hff},
    '{2'd0, bam_cmd_pkg::OP_READ,  32'h0000_0028, 4'd1,  8'hf0},
    '{2'd0, bam_cmd_pkg::OP_READ,  32'h0000_0060, 4'd2,  8'h3c},
    '{2'd0, bam_cmd_pkg::OP_WRITE, 32'h0040_0000, 4'd1,  8'h00},
    '{2'd0, bam_cmd_pkg::OP_WRITE, 32'h0020_0007, 4'd1,  8'h00},
    '{2'd0, bam_cmd_pkg::OP_READ,  32'h0040_0000, 4'd1,  8'hff},
    '{2'd1, bam_cmd_pkg::OP_READ,  32'h0000_2000, 4'd15, 8'hff},
    '{2'd1, bam_cmd_pkg::OP_READ,  32'h0000_2100, 4'd15, 8'hff},
    '{2'd1, bam_cmd_pkg::OP_READ,  32'h0000_2200, 4'd15, 8'hff},
    '{2'd1, bam_cmd_pkg::OP_READ,  32'h0000_2300, 4'd15, 8'hff},
    '{2'd1, bam_cmd_pkg::OP_READ,  32'h0000_2400, 4'd15, 8'hff},
    '{2'd1, bam_cmd_pkg::OP_READ,  32'h0000_2500, 4'd15, 8'hff},
    '{2'd2, bam_cmd_pkg::OP_WRITE, 32'h0000_3000, 4'd3,  8'h00},
    '{2'd2, bam_cmd_pkg::OP_READ,  32'h0000_3000, 4'd3,  8'h81}
  };

  logic                    clk = 1'b0;
  logic                    srst_reg;
  logic                    cmd_empty_i;
  bam_cmd_pkg::bam_cmd_t   cmd_rdata_i;
  logic                    cmd_pop_o;
  bam_bus_pkg::bam_data_t  wdata_i;
  bam_bus_pkg::bam_be_t    wbe_i;
  logic                    wdata_pop_o;
  logic                    bus_write_o;
  logic                    bus_read_o;
  bam_bus_pkg::bam_addr_t  bus_addr_o;
  bam_bus_pkg::bam_data_t  bus_wdata_o;
  bam_bus_pkg::bam_be_t    bus_be_o;
  bam_bus_pkg::bam_burst_t bus_burst_o;
  logic                    bus_waitreq_i;
  bam_bus_pkg::bam_data_t  bus_rdata_i;
  logic                    bus_rvalid_i;
  bam_bus_pkg::bam_resp_t  bus_resp_i;
  logic                    cpl_empty_o;
  bam_bus_pkg::bam_cpl_t   cpl_data_o;
  logic                    cpl_pop_i;

  bam_cmd_pkg::bam_cmd_t   cmd_fifo [$];
  bam_bus_pkg::bam_data_t  wdata_fifo [$];
  bam_bus_pkg::bam_be_t    wbe_fifo [$];
  exp_wr_t                 exp_wr [$];
  exp_rd_t                 exp_rd [$];
  exp_cpl_t                exp_cpl [$];
  beat_t                   rd_pend [$];
  bam_bus_pkg::bam_data_t  ref_mem [bam_bus_pkg::bam_addr_t];
  bam_bus_pkg::bam_data_t  slave_mem [bam_bus_pkg::bam_addr_t];

  logic                    cmd_pop_seen = 1'b0;
  logic                    wdata_pop_seen = 1'b0;
  logic                    cons_en = 1'b0;
  int                      rd_gap = 0;
  int                      wr_left = 0;
  bam_bus_pkg::bam_addr_t  wr_addr;
  int                      cmd_pops = 0;
  int                      rd_beats_req = 0;
  int                      cpl_pops = 0;

  always #10 clk = ~clk;

  bam_master_top i_dut (
    .clk           ( clk           ),
    .srst_reg      ( srst_reg      ),
    .cmd_empty_i   ( cmd_empty_i   ),
    .cmd_rdata_i   ( cmd_rdata_i   ),
    .cmd_pop_o     ( cmd_pop_o     ),
    .wdata_i       ( wdata_i       ),
    .wbe_i         ( wbe_i         ),
    .wdata_pop_o   ( wdata_pop_o   ),
    .bus_write_o   ( bus_write_o   ),
    .bus_read_o    ( bus_read_o    ),
    .bus_addr_o    ( bus_addr_o    ),
    .bus_wdata_o   ( bus_wdata_o   ),
    .bus_be_o      ( bus_be_o      ),
    .bus_burst_o   ( bus_burst_o   ),
    .bus_waitreq_i ( bus_waitreq_i ),
    .bus_rdata_i   ( bus_rdata_i   ),
    .bus_rvalid_i  ( bus_rvalid_i  ),
    .bus_resp_i    ( bus_resp_i    ),
    .cpl_empty_o   ( cpl_empty_o   ),
    .cpl_data_o    ( cpl_data_o    ),
    .cpl_pop_i     ( cpl_pop_i     )
  );

  // --------------------------------------------------
  // reporting and reference helpers
  // --------------------------------------------------
  task automatic stop_on_error(string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_field(string what, logic [63:0] expected, logic [63:0] actual);
    assert (actual === expected) else
      stop_on_error($sformatf("Mismatch %s: expected 0x%0h, actual 0x%0h",
                              what, expected, actual));
  endtask

  function automatic string test_name(int idx);
    string grp;
    case (tbl[idx].grp)
      2'd0:    grp = "basic";
      2'd1:    grp = "credit";
      default: grp = "waitreq";
    endcase
    return $sformatf("%s entry %0d", grp, idx);
  endfunction

  // memory fill that is unique for every word address
  function automatic bam_bus_pkg::bam_data_t fill_word(bam_bus_pkg::bam_addr_t a);
    return {a ^ 32'h9e37_79b9, ~a};
  endfunction

  // slave response on a few chosen word addresses
  function automatic bam_bus_pkg::bam_resp_t resp_for(bam_bus_pkg::bam_addr_t a);
    case (a[8:3])
      6'h05:   return 2'b10;
      6'h0c:   return 2'b01;
      6'h0f:   return 2'b11;
      default: return 2'b00;
    endcase
  endfunction

  function automatic bam_bus_pkg::bam_data_t merge_bytes(bam_bus_pkg::bam_data_t old_w,
                                                         bam_bus_pkg::bam_data_t new_w,
                                                         bam_bus_pkg::bam_be_t be);
    bam_bus_pkg::bam_data_t res;
    res = old_w;
    for (int b = 0; b < `BAM_BE_W; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic bam_bus_pkg::bam_data_t read_ref(bam_bus_pkg::bam_addr_t a);
    return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
  endfunction

  function automatic bam_bus_pkg::bam_data_t read_slave(bam_bus_pkg::bam_addr_t a);
    return slave_mem.exists(a) ? slave_mem[a] : fill_word(a);
  endfunction

  // --------------------------------------------------
  // stimulus from one table entry into the FIFO models
  // --------------------------------------------------
  task automatic apply_entry(int i);
    tbl_entry_t             e;
    bam_bus_pkg::bam_addr_t base;
    bam_bus_pkg::bam_addr_t a;
    bam_bus_pkg::bam_data_t d;
    bam_bus_pkg::bam_be_t   be;
    logic                   win;
    exp_wr_t                w;
    exp_rd_t                r;
    exp_cpl_t               c;
    bam_cmd_pkg::bam_cmd_t  cmd;
    e = tbl[i];
    base = {e.addr[`BAM_ADDR_W-1:`BAM_ALIGN_BITS], {`BAM_ALIGN_BITS{1'b0}}};
    win = |base[`BAM_WIN_HI:`BAM_WIN_LO];
    if (e.op == bam_cmd_pkg::OP_WRITE) begin
      // data goes in ahead of its command
      for (int k = 0; k < int'(e.burst); k++) begin
        d = {$urandom, $urandom};
        be = bam_bus_pkg::bam_be_t'($urandom);
        wdata_fifo.push_back(d);
        wbe_fifo.push_back(be);
        if (!win) begin
          a = base + bam_bus_pkg::bam_addr_t'(8 * k);
          ref_mem[a] = merge_bytes(read_ref(a), d, be);
          w.idx = 8'(i);
          w.first = (k == 0);
          w.addr = base;
          w.data = d;
          w.be = be;
          w.burst = e.burst;
          exp_wr.push_back(w);
        end
      end
    end else begin
      r.idx = 8'(i);
      r.addr = base;
      r.be = e.be;
      r.burst = e.burst;
      exp_rd.push_back(r);
      for (int k = 0; k < int'(e.burst); k++) begin
        a = base + bam_bus_pkg::bam_addr_t'(8 * k);
        c.idx = 8'(i);
        c.cpl.err = |resp_for(a);
        c.cpl.data = read_ref(a);
        exp_cpl.push_back(c);
      end
    end
    cmd.op = e.op;
    cmd.burst = e.burst;
    cmd.be = e.be;
    cmd.addr = e.addr;
    cmd_fifo.push_back(cmd);
  endtask

  // --------------------------------------------------
  // output monitor sampled mid cycle
  // --------------------------------------------------
  task automatic monitor_outputs();
    exp_wr_t                w;
    exp_rd_t                r;
    exp_cpl_t               c;
    beat_t                  beat;
    bam_bus_pkg::bam_addr_t a;
    string                  tn;
    int                     outstanding;
    cmd_pop_seen = cmd_pop_o;
    wdata_pop_seen = wdata_pop_o;
    if (cmd_pop_o) begin
      cmd_pops++;
    end
    if (bus_write_o) begin
      assert (exp_wr.size() > 0) else stop_on_error("bus write seen while none was expected");
      w = exp_wr.pop_front();
      tn = test_name(int'(w.idx));
      assert (w.first == (wr_left == 0)) else
        stop_on_error($sformatf("write burst has the wrong length in %s", tn));
      check_field({tn, " bus_addr_o"}, w.addr, bus_addr_o);
      check_field({tn, " bus_wdata_o"}, w.data, bus_wdata_o);
      check_field({tn, " bus_be_o"}, w.be, bus_be_o);
      check_field({tn, " bus_burst_o"}, w.burst, bus_burst_o);
      wr_left = w.first ? int'(w.burst) - 1 : wr_left - 1;
      wr_addr = w.first ? bus_addr_o : wr_addr + 8;
      slave_mem[wr_addr] = merge_bytes(read_slave(wr_addr), bus_wdata_o, bus_be_o);
    end else begin
      assert (wr_left == 0) else stop_on_error("write burst stopped before its last beat");
    end
    if (bus_read_o) begin
      assert (exp_rd.size() > 0) else stop_on_error("bus read seen while none was expected");
      r = exp_rd.pop_front();
      tn = test_name(int'(r.idx));
      check_field({tn, " bus_addr_o"}, r.addr, bus_addr_o);
      check_field({tn, " bus_be_o"}, r.be, bus_be_o);
      check_field({tn, " bus_burst_o"}, r.burst, bus_burst_o);
      rd_beats_req += int'(bus_burst_o);
      outstanding = rd_beats_req - cpl_pops;
      assert (outstanding <= `BAM_CPL_DEPTH - `BAM_MAX_BURST + int'(bus_burst_o)) else
        stop_on_error($sformatf("Mismatch %s credit limit: expected at most %0d, actual %0d",
                                tn, `BAM_CPL_DEPTH - `BAM_MAX_BURST + int'(bus_burst_o),
                                outstanding));
      if (rd_pend.size() == 0) begin
        rd_gap = $urandom_range(1, 6);
      end
      // slave snapshots the data when the request arrives
      for (int k = 0; k < int'(bus_burst_o); k++) begin
        a = bus_addr_o + bam_bus_pkg::bam_addr_t'(8 * k);
        beat.data = read_slave(a);
        beat.resp = resp_for(a);
        rd_pend.push_back(beat);
      end
    end
    if (cpl_pop_i) begin
      assert (exp_cpl.size() > 0) else stop_on_error("completion present while none expected");
      c = exp_cpl.pop_front();
      tn = test_name(int'(c.idx));
      check_field({tn, " completion err"}, c.cpl.err, cpl_data_o.err);
      check_field({tn, " completion data"}, c.cpl.data, cpl_data_o.data);
      cpl_pops++;
    end
  endtask

  // --------------------------------------------------
  // FIFO, slave and consumer models
  // --------------------------------------------------
  task automatic drive_inputs();
    beat_t beat;
    if (cmd_pop_seen) begin
      assert (cmd_fifo.size() > 0) else stop_on_error("command FIFO popped while empty");
      void'(cmd_fifo.pop_front());
    end
    if (wdata_pop_seen) begin
      assert (wdata_fifo.size() > 0) else stop_on_error("write data FIFO popped while empty");
      void'(wdata_fifo.pop_front());
      void'(wbe_fifo.pop_front());
    end
    cmd_empty_i = (cmd_fifo.size() == 0);
    if (cmd_fifo.size() > 0) begin
      cmd_rdata_i = cmd_fifo[0];
    end
    if (wdata_fifo.size() > 0) begin
      wdata_i = wdata_fifo[0];
      wbe_i = wbe_fifo[0];
    end
    if (rd_pend.size() > 0 && rd_gap == 0) begin
      beat = rd_pend.pop_front();
      bus_rvalid_i = 1'b1;
      bus_rdata_i = beat.data;
      bus_resp_i = beat.resp;
      rd_gap = $urandom_range(0, 2);
    end else begin
      bus_rvalid_i = 1'b0;
      bus_resp_i = 2'b00;
      if (rd_gap > 0) begin
        rd_gap--;
      end
    end
    cpl_pop_i = cons_en && !cpl_empty_o && ($urandom_range(0, 3) != 0);
  endtask

  initial begin : models
    cmd_empty_i = 1'b1;
    cmd_rdata_i = '0;
    wdata_i = '0;
    wbe_i = '0;
    bus_rdata_i = '0;
    bus_rvalid_i = 1'b0;
    bus_resp_i = 2'b00;
    cpl_pop_i = 1'b0;
    forever begin
      @(negedge clk);
      if (!srst_reg) begin
        monitor_outputs();
      end
      @(posedge clk);
      #1;
      drive_inputs();
    end
  end

  task automatic wait_drain(string what);
    int cycles;
    cycles = 0;
    while (cmd_fifo.size() != 0 || wdata_fifo.size() != 0 || exp_wr.size() != 0 ||
           exp_rd.size() != 0 || exp_cpl.size() != 0) begin
      @(negedge clk);
      cycles++;
      assert (cycles < DRAIN_LIMIT) else
        stop_on_error($sformatf("timeout while the %s group was draining", what));
    end
    @(negedge clk);
    check_field({what, " cpl_empty_o after drain"}, 1, cpl_empty_o);
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin : main
    int base_beats;
    int stall_beats;
    int pops_before;
    int cycles;
    void'($urandom(92));
    srst_reg = 1'b1;
    bus_waitreq_i = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    srst_reg = 1'b0;

    repeat (5) begin
      @(negedge clk);
      check_field("reset cmd_pop_o", 0, cmd_pop_o);
      check_field("reset wdata_pop_o", 0, wdata_pop_o);
      check_field("reset bus_write_o", 0, bus_write_o);
      check_field("reset bus_read_o", 0, bus_read_o);
      check_field("reset cpl_empty_o", 1, cpl_empty_o);
    end

    cons_en = 1'b1;
    base_beats = 0;
    pops_before = 0;
    // reads of full bursts that fit before credit_ok drops
    stall_beats = ((`BAM_CPL_DEPTH - `BAM_MAX_BURST) / `BAM_MAX_BURST + 1) * `BAM_MAX_BURST;
    for (int g = 0; g < 3; g++) begin
      if (g == 1) begin
        cons_en = 1'b0;
        base_beats = rd_beats_req;
      end
      if (g == 2) begin
        @(posedge clk);
        #1;
        bus_waitreq_i = 1'b1;
        pops_before = cmd_pops;
      end
      for (int i = 0; i < NUM_ENTRIES; i++) begin
        if (int'(tbl[i].grp) == g) begin
          @(negedge clk);
          apply_entry(i);
        end
      end
      if (g == 1) begin
        cycles = 0;
        while (rd_beats_req < base_beats + stall_beats) begin
          @(negedge clk);
          cycles++;
          assert (cycles < DRAIN_LIMIT) else
            stop_on_error("timeout waiting for the reads ahead of the credit stall");
        end
        repeat (30) @(negedge clk);
        check_field("credit beats requested without pops", base_beats + stall_beats,
                    rd_beats_req);
        cons_en = 1'b1;
      end
      if (g == 2) begin
        repeat (20) @(negedge clk);
        check_field("waitreq commands popped while held", pops_before, cmd_pops);
        @(posedge clk);
        #1;
        bus_waitreq_i = 1'b0;
      end
      wait_drain(g == 0 ? "basic" : (g == 1 ? "credit" : "waitreq"));
    end

    $display("** PASS **");
    $finish;
  end

endmodule
